/* include/mmu_params.svh */
// page memory manager dispatcher parameters
// widths, page limit, free threshold and settle times

`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// request fields
`define REQ_ID_WIDTH        8
`define PAGE_IDX_WIDTH      16
`define PAGE_COUNT_WIDTH    4

// largest page count accepted, anything above is rejected
`define MAX_PAGES           8

// free fifo occupancy as reported by the fifo
`define FIFO_COUNT_WIDTH    7

// free backlog that forces arbitration over to free
`define FREE_THRESHOLD      64

// settle time after a path switch, in cycles
`define FREE_SETTLE_CYCLES  5
`define ALLOC_SETTLE_CYCLES 6

`endif

/* verilog/mmu_types_pkg.sv */
// request, issue and response types of the page dispatcher
// shared by the screens and the top level

package mmu_types_pkg;

`include "mmu_params.svh"

    // rounded allocation size, one page is 512 B
    typedef enum logic [1:0] {
        SIZE_512,
        SIZE_1K,
        SIZE_2K,
        SIZE_4K
    } size_class_t;

    typedef enum logic [1:0] {
        FAIL_NONE,
        FAIL_ZERO,      // page count of zero
        FAIL_OVERSIZE   // more than MAX_PAGES
    } fail_reason_t;

    // entry of the alloc and free request fifos
    typedef struct packed {
        logic [`REQ_ID_WIDTH-1:0]     id;
        logic [`PAGE_COUNT_WIDTH-1:0] page_count;
        logic [`PAGE_IDX_WIDTH-1:0]   page_idx;   // meaningful on free only
    } page_req_t;

    // request sent on to the allocator or the free tree
    typedef struct packed {
        logic                         valid;  // single cycle pulse
        logic [`REQ_ID_WIDTH-1:0]     id;
        logic [`PAGE_IDX_WIDTH-1:0]   page_idx;
        size_class_t                  size;
        logic [`PAGE_COUNT_WIDTH-1:0] origin_count;
    } page_issue_t;

    // entry written into a response fifo
    typedef struct packed {
        logic                         write_en;
        logic [`REQ_ID_WIDTH-1:0]     id;
        logic                         fail;
        fail_reason_t                 reason;
        logic [`PAGE_COUNT_WIDTH-1:0] origin_count;
    } page_rsp_t;

endpackage

/* verilog/dispatch_ctrl_pkg.sv */
// control types of the dispatcher FSM and switch timer

package dispatch_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,    // arbitration
        ST_FETCH,   // pop the chosen fifo
        ST_CHECK,   // entry valid at fifo output, strobe the screen
        ST_SETTLE,  // wait out the switch timer
        ST_SPIN1,
        ST_SPIN2
    } disp_state_t;

    typedef enum logic {
        PATH_ALLOC,
        PATH_FREE
    } path_t;

endpackage

/* verilog/dispatch_fsm.sv */
// dispatcher FSM
// arbitrates alloc and free fifos, pops, strobes the screens and runs the switch timer

`timescale 1ns/1ps

`include "mmu_params.svh"

module dispatch_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          alloc_empty,
    input  logic                          free_empty,
    input  logic [`FIFO_COUNT_WIDTH-1:0]  free_count,
    input  logic                          alloc_rsp_almost_full,
    input  logic                          free_rsp_almost_full,
    input  logic                          timer_done,
    output logic                          alloc_pop,
    output logic                          free_pop,
    output logic                          load_alloc,
    output logic                          load_free,
    output logic                          hold,
    output logic                          timer_start,
    output dispatch_ctrl_pkg::path_t      timer_path
);

    localparam logic [`FIFO_COUNT_WIDTH-1:0] FREE_THRESH = `FREE_THRESHOLD;

    dispatch_ctrl_pkg::disp_state_t state;
    dispatch_ctrl_pkg::disp_state_t state_next;
    dispatch_ctrl_pkg::path_t       cur_path;     // path being fetched
    dispatch_ctrl_pkg::path_t       path_next;
    dispatch_ctrl_pkg::path_t       last_path;    // last path that got a request
    logic                           switch_pending;
    logic                           switch_next;
    logic                           can_alloc;
    logic                           can_free;
    logic                           free_backlog;

    // a path may go only with work queued and room for its response
    assign can_alloc    = !alloc_empty && !alloc_rsp_almost_full;
    assign can_free     = !free_empty && !free_rsp_almost_full;
    assign free_backlog = free_count >= FREE_THRESH;

    always_comb begin
        state_next  = state;
        path_next   = cur_path;
        switch_next = switch_pending;
        case (state)
            dispatch_ctrl_pkg::ST_IDLE: begin
                if (!can_alloc && !can_free) begin
                    state_next = dispatch_ctrl_pkg::ST_SPIN1;
                end else begin
                    state_next = dispatch_ctrl_pkg::ST_FETCH;
                    if (last_path == dispatch_ctrl_pkg::PATH_ALLOC) begin
                        // leave alloc on backlog, or when only free can move
                        if (can_free && (free_backlog || !can_alloc)) begin
                            path_next = dispatch_ctrl_pkg::PATH_FREE;
                        end else begin
                            path_next = dispatch_ctrl_pkg::PATH_ALLOC;
                        end
                    end else begin
                        // free keeps going until drained or its rsp fifo fills
                        if (can_free) begin
                            path_next = dispatch_ctrl_pkg::PATH_FREE;
                        end else begin
                            path_next = dispatch_ctrl_pkg::PATH_ALLOC;
                        end
                    end
                    switch_next = (path_next != last_path);
                end
            end
            dispatch_ctrl_pkg::ST_FETCH: begin
                // back to arbitration if the path lost its chance meanwhile
                if (alloc_pop || free_pop) begin
                    state_next = dispatch_ctrl_pkg::ST_CHECK;
                end else begin
                    state_next = dispatch_ctrl_pkg::ST_IDLE;
                end
            end
            dispatch_ctrl_pkg::ST_CHECK: begin
                if (switch_pending) begin
                    state_next = dispatch_ctrl_pkg::ST_SETTLE;
                end else begin
                    state_next = dispatch_ctrl_pkg::ST_IDLE;
                end
            end
            dispatch_ctrl_pkg::ST_SETTLE: begin
                if (timer_done) begin
                    state_next = dispatch_ctrl_pkg::ST_IDLE;
                end
            end
            dispatch_ctrl_pkg::ST_SPIN1: state_next = dispatch_ctrl_pkg::ST_SPIN2;
            dispatch_ctrl_pkg::ST_SPIN2: state_next = dispatch_ctrl_pkg::ST_IDLE;
            default:                     state_next = dispatch_ctrl_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= dispatch_ctrl_pkg::ST_IDLE;
            cur_path       <= dispatch_ctrl_pkg::PATH_ALLOC;
            last_path      <= dispatch_ctrl_pkg::PATH_ALLOC;  // alloc has priority out of reset
            switch_pending <= 1'b0;
        end else begin
            state          <= state_next;
            cur_path       <= path_next;
            switch_pending <= switch_next;
            if (state == dispatch_ctrl_pkg::ST_CHECK) begin
                last_path <= cur_path;
            end
        end
    end

    // pop is combinational and the entry shows up on the next cycle
    assign alloc_pop = (state == dispatch_ctrl_pkg::ST_FETCH) &&
                       (cur_path == dispatch_ctrl_pkg::PATH_ALLOC) && can_alloc;
    assign free_pop  = (state == dispatch_ctrl_pkg::ST_FETCH) &&
                       (cur_path == dispatch_ctrl_pkg::PATH_FREE) && can_free;

    assign load_alloc  = (state == dispatch_ctrl_pkg::ST_CHECK) &&
                         (cur_path == dispatch_ctrl_pkg::PATH_ALLOC);
    assign load_free   = (state == dispatch_ctrl_pkg::ST_CHECK) &&
                         (cur_path == dispatch_ctrl_pkg::PATH_FREE);
    assign timer_start = (state == dispatch_ctrl_pkg::ST_CHECK) && switch_pending;
    assign hold        = timer_start;    // first request after a switch waits for the timer
    assign timer_path  = cur_path;

    a_single_pop: assert property (@(posedge clk) disable iff (!rst_n)
        !(alloc_pop && free_pop));

    a_alloc_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_pop |-> !alloc_empty);

    a_free_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        free_pop |-> !free_empty);

endmodule

/* verilog/switch_timer.sv */
// settle timer for path switches
// loads the settle time of the new path on start, pulses done when it runs out

`timescale 1ns/1ps

`include "mmu_params.svh"

module switch_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  dispatch_ctrl_pkg::path_t path,
    output logic                     done
);

    localparam int MAX_SETTLE = (`ALLOC_SETTLE_CYCLES > `FREE_SETTLE_CYCLES) ?
                                `ALLOC_SETTLE_CYCLES : `FREE_SETTLE_CYCLES;
    localparam int CNT_W      = $clog2(MAX_SETTLE + 1);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] load_val;
    logic             busy;

    assign load_val = (path == dispatch_ctrl_pkg::PATH_FREE) ? CNT_W'(`FREE_SETTLE_CYCLES) :
                                                              CNT_W'(`ALLOC_SETTLE_CYCLES);

    assign done = busy && (cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= load_val;
        end else if (done) begin
            busy <= 1'b0;          // single pulse
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) !(start && busy));

endmodule

/* verilog/req_screen.sv */
// request screen for one path
// rejects bad page counts with a fail response, rounds good ones to a size class and issues them

`timescale 1ns/1ps

`include "mmu_params.svh"

module req_screen #(
    parameter bit CARRY_IDX = 1'b0      // free passes the page index on, alloc sends zero
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load,
    input  logic                      hold,
    input  logic                      release_en,
    input  mmu_types_pkg::page_req_t  req,
    output mmu_types_pkg::page_issue_t issue,
    output mmu_types_pkg::page_rsp_t   rsp
);

    mmu_types_pkg::size_class_t  size_cls;
    mmu_types_pkg::fail_reason_t reason;
    logic                        req_ok;

    logic                         issue_valid;
    logic                         rsp_we;
    logic                         pending;    // good request waiting for release
    logic [`REQ_ID_WIDTH-1:0]     iss_id;
    logic [`PAGE_IDX_WIDTH-1:0]   iss_idx;
    mmu_types_pkg::size_class_t   iss_size;
    logic [`PAGE_COUNT_WIDTH-1:0] iss_count;
    logic [`REQ_ID_WIDTH-1:0]     rsp_id;
    mmu_types_pkg::fail_reason_t  rsp_reason;
    logic [`PAGE_COUNT_WIDTH-1:0] rsp_count;

    always_comb begin
        if (req.page_count == '0) begin
            reason = mmu_types_pkg::FAIL_ZERO;
        end else if (req.page_count > `MAX_PAGES) begin
            reason = mmu_types_pkg::FAIL_OVERSIZE;
        end else begin
            reason = mmu_types_pkg::FAIL_NONE;
        end
    end

    assign req_ok = (reason == mmu_types_pkg::FAIL_NONE);

    // round up to the next power of two pages
    always_comb begin
        case (req.page_count)
            1:       size_cls = mmu_types_pkg::SIZE_512;
            2:       size_cls = mmu_types_pkg::SIZE_1K;
            3, 4:    size_cls = mmu_types_pkg::SIZE_2K;
            default: size_cls = mmu_types_pkg::SIZE_4K;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
            rsp_we      <= 1'b0;
            pending     <= 1'b0;
        end else begin
            issue_valid <= 1'b0;
            rsp_we      <= 1'b0;
            if (load) begin
                issue_valid <= req_ok && !hold;
                pending     <= req_ok && hold;
                rsp_we      <= !req_ok;       // rejects never wait for the timer
            end else if (release_en && pending) begin
                issue_valid <= 1'b1;
                pending     <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && req_ok) begin
            iss_id    <= req.id;
            iss_idx   <= CARRY_IDX ? req.page_idx : '0;
            iss_size  <= size_cls;
            iss_count <= req.page_count;
        end
        if (load && !req_ok) begin
            rsp_id     <= req.id;
            rsp_reason <= reason;
            rsp_count  <= req.page_count;
        end
    end

    always_comb begin
        issue.valid        = issue_valid;
        issue.id           = iss_id;
        issue.page_idx     = iss_idx;
        issue.size         = iss_size;
        issue.origin_count = iss_count;
        rsp.write_en       = rsp_we;
        rsp.id             = rsp_id;
        rsp.fail           = (rsp_reason != mmu_types_pkg::FAIL_NONE);
        rsp.reason         = rsp_reason;
        rsp.origin_count   = rsp_count;
    end

    // one request gives either an issue or a response, never both
    a_issue_or_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        !(issue_valid && rsp_we));

endmodule

/* verilog/mmu_dispatcher.sv */
// page memory manager request dispatcher
// feeds alloc and free requests from their fifos to the allocator and the free tree

`timescale 1ns/1ps

`include "mmu_params.svh"

module mmu_dispatcher (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mmu_types_pkg::page_req_t      alloc_req,
    input  mmu_types_pkg::page_req_t      free_req,
    input  logic                          alloc_empty,
    input  logic                          free_empty,
    input  logic [`FIFO_COUNT_WIDTH-1:0]  free_count,
    input  logic                          alloc_rsp_almost_full,
    input  logic                          free_rsp_almost_full,
    output logic                          alloc_pop,
    output logic                          free_pop,
    output mmu_types_pkg::page_issue_t    alloc_issue,
    output mmu_types_pkg::page_issue_t    free_issue,
    output mmu_types_pkg::page_rsp_t      alloc_rsp,
    output mmu_types_pkg::page_rsp_t      free_rsp
);

    logic                     load_alloc;
    logic                     load_free;
    logic                     hold;
    logic                     timer_start;
    logic                     timer_done;   // also releases the held issue
    dispatch_ctrl_pkg::path_t timer_path;

    dispatch_fsm u_fsm (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .alloc_empty           (alloc_empty),
        .free_empty            (free_empty),
        .free_count            (free_count),
        .alloc_rsp_almost_full (alloc_rsp_almost_full),
        .free_rsp_almost_full  (free_rsp_almost_full),
        .timer_done            (timer_done),
        .alloc_pop             (alloc_pop),
        .free_pop              (free_pop),
        .load_alloc            (load_alloc),
        .load_free             (load_free),
        .hold                  (hold),
        .timer_start           (timer_start),
        .timer_path            (timer_path)
    );

    switch_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .path  (timer_path),
        .done  (timer_done)
    );

    req_screen #(.CARRY_IDX(1'b0)) u_alloc_screen (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load_alloc),
        .hold       (hold),
        .release_en (timer_done),
        .req        (alloc_req),
        .issue      (alloc_issue),
        .rsp        (alloc_rsp)
    );

    req_screen #(.CARRY_IDX(1'b1)) u_free_screen (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load_free),
        .hold       (hold),
        .release_en (timer_done),
        .req        (free_req),
        .issue      (free_issue),
        .rsp        (free_rsp)
    );

endmodule

/* verif/tb_mmu_dispatcher.sv */
// testbench for the page memory request dispatcher
// queue FIFO models, random traffic and a per-path reference model

`timescale 1ns/1ps

`include "mmu_params.svh"

module tb_mmu_dispatcher;

    typedef logic [`PAGE_COUNT_WIDTH-1:0] count_t;
    typedef logic [`PAGE_IDX_WIDTH-1:0]   idx_t;
    typedef logic [`REQ_ID_WIDTH-1:0]     id_t;

    // one popped request and the single result it should produce
    typedef struct packed {
        logic                       is_issue;
        mmu_types_pkg::page_issue_t issue;
        mmu_types_pkg::page_rsp_t   rsp;
        int                         pop_cycle;
    } exp_entry_t;

    localparam int AF_RANDOM      = 0;
    localparam int AF_FREE_FULL   = 1;
    localparam int AF_CLEAR       = 2;
    localparam int RESULT_TIMEOUT = 32;     // cycles from pop to result
    localparam int DRAIN_TIMEOUT  = 20000;

    logic                           clk;
    logic                           rst_n;
    mmu_types_pkg::page_req_t       alloc_req;
    mmu_types_pkg::page_req_t       free_req;
    logic                           alloc_empty;
    logic                           free_empty;
    logic [`FIFO_COUNT_WIDTH-1:0]   free_count;
    logic                           alloc_rsp_almost_full;
    logic                           free_rsp_almost_full;
    logic                           alloc_pop;
    logic                           free_pop;
    mmu_types_pkg::page_issue_t     alloc_issue;
    mmu_types_pkg::page_issue_t     free_issue;
    mmu_types_pkg::page_rsp_t       alloc_rsp;
    mmu_types_pkg::page_rsp_t       free_rsp;

    mmu_types_pkg::page_req_t alloc_q[$];     // FIFO contents
    mmu_types_pkg::page_req_t free_q[$];
    mmu_types_pkg::page_req_t alloc_out;      // entry presented after a pop
    mmu_types_pkg::page_req_t free_out;
    exp_entry_t               alloc_exp[$];
    exp_entry_t               free_exp[$];
    id_t                      alloc_id;
    id_t                      free_id;
    int                       cycle;
    int                       value_errors;
    int                       other_errors;
    int                       wait_cycles;
    logic                     quiet;          // both FIFOs empty since reset

    mmu_dispatcher u_dut (.*);

    always #5 clk = ~clk;

    function automatic mmu_types_pkg::page_req_t make_req(input id_t id);
        mmu_types_pkg::page_req_t r;
        r.id = id;
        if ($urandom_range(0, 3) != 0) begin
            r.page_count = count_t'($urandom_range(1, `MAX_PAGES));
        end else begin
            r.page_count = count_t'($urandom_range(0, 15));   // zero and oversize live here
        end
        r.page_idx = idx_t'($urandom);
        return r;
    endfunction

    function automatic mmu_types_pkg::size_class_t expected_size(input count_t n);
        if (n <= 1) return mmu_types_pkg::SIZE_512;
        if (n == 2) return mmu_types_pkg::SIZE_1K;
        if (n <= 4) return mmu_types_pkg::SIZE_2K;
        return mmu_types_pkg::SIZE_4K;
    endfunction

    function automatic exp_entry_t build_expect(input mmu_types_pkg::page_req_t req,
                                                input bit carry_idx, input int cyc);
        exp_entry_t e;
        e = '0;
        e.pop_cycle = cyc;
        if (req.page_count == 0 || req.page_count > `MAX_PAGES) begin
            e.rsp.write_en     = 1'b1;
            e.rsp.id           = req.id;
            e.rsp.fail         = 1'b1;
            e.rsp.reason       = (req.page_count == 0) ? mmu_types_pkg::FAIL_ZERO :
                                                         mmu_types_pkg::FAIL_OVERSIZE;
            e.rsp.origin_count = req.page_count;
        end else begin
            e.is_issue           = 1'b1;
            e.issue.valid        = 1'b1;
            e.issue.id           = req.id;
            e.issue.page_idx     = carry_idx ? req.page_idx : '0;   // alloc sends no index
            e.issue.size         = expected_size(req.page_count);
            e.issue.origin_count = req.page_count;
        end
        return e;
    endfunction

    function automatic int exp_count(input bit is_free);
        return is_free ? free_exp.size() : alloc_exp.size();
    endfunction

    function automatic exp_entry_t take_expect(input bit is_free);
        return is_free ? free_exp.pop_front() : alloc_exp.pop_front();
    endfunction

    function automatic int head_cycle(input bit is_free);
        return is_free ? free_exp[0].pop_cycle : alloc_exp[0].pop_cycle;
    endfunction

    function automatic bit all_done();
        return alloc_q.size() == 0 && free_q.size() == 0 &&
               alloc_exp.size() == 0 && free_exp.size() == 0;
    endfunction

    task automatic check_issue(input string name, input mmu_types_pkg::page_issue_t exp,
                               input mmu_types_pkg::page_issue_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s expected %p actual %p", name, exp, act);
        end
    endtask

    task automatic check_rsp(input string name, input mmu_types_pkg::page_rsp_t exp,
                             input mmu_types_pkg::page_rsp_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s expected %p actual %p", name, exp, act);
        end
    endtask

    // match one path's outputs against the oldest outstanding request
    task automatic check_path(input bit is_free, input mmu_types_pkg::page_issue_t iss,
                              input mmu_types_pkg::page_rsp_t rsp);
        string      name;
        exp_entry_t e;
        name = is_free ? "free" : "alloc";
        if (iss.valid) begin
            if (exp_count(is_free) == 0) begin
                other_errors++;
                $display("%s issue seen with no request outstanding", name);
            end else begin
                e = take_expect(is_free);
                if (!e.is_issue) begin
                    other_errors++;
                    $display("%s issue made for rejected request id %0d", name, e.rsp.id);
                end else begin
                    check_issue({name, "_issue"}, e.issue, iss);
                end
            end
        end
        if (rsp.write_en) begin
            if (exp_count(is_free) == 0) begin
                other_errors++;
                $display("%s response written with no request outstanding", name);
            end else begin
                e = take_expect(is_free);
                if (e.is_issue) begin
                    other_errors++;
                    $display("%s response written for valid request id %0d", name, e.issue.id);
                end else begin
                    check_rsp({name, "_rsp"}, e.rsp, rsp);
                end
            end
        end
        if (exp_count(is_free) > 0 && cycle - head_cycle(is_free) > RESULT_TIMEOUT) begin
            e = take_expect(is_free);
            other_errors++;
            $display("%s request popped at cycle %0d gave no result in %0d cycles",
                     name, e.pop_cycle, RESULT_TIMEOUT);
        end
    endtask

    // outputs are registered, so they are sampled on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            if (quiet && (alloc_pop || free_pop || alloc_issue.valid || free_issue.valid ||
                          alloc_rsp.write_en || free_rsp.write_en)) begin
                other_errors++;
                $display("DUT output active while both FIFOs stayed empty after reset");
            end
            if (alloc_pop && alloc_rsp_almost_full) begin
                other_errors++;
                $display("alloc popped while its response FIFO was almost full");
            end
            if (free_pop && free_rsp_almost_full) begin
                other_errors++;
                $display("free popped while its response FIFO was almost full");
            end
            check_path(1'b0, alloc_issue, alloc_rsp);
            check_path(1'b1, free_issue, free_rsp);
            if (alloc_pop) begin
                if (alloc_q.size() == 0) begin
                    other_errors++;
                    $display("alloc popped while the alloc FIFO was empty");
                end else begin
                    alloc_out = alloc_q.pop_front();
                    alloc_exp.push_back(build_expect(alloc_out, 1'b0, cycle));
                end
            end
            if (free_pop) begin
                if (free_q.size() == 0) begin
                    other_errors++;
                    $display("free popped while the free FIFO was empty");
                end else begin
                    free_out = free_q.pop_front();
                    free_exp.push_back(build_expect(free_out, 1'b1, cycle));
                end
            end
        end
    end

    task automatic drive_cycle(input int alloc_pct, input int free_pct, input int af_mode);
        @(negedge clk);
        alloc_req = alloc_out;   // popped entry shows on the cycle after the pop
        free_req  = free_out;
        if (int'($urandom_range(0, 99)) < alloc_pct) begin
            alloc_q.push_back(make_req(alloc_id));
            alloc_id++;
        end
        if (int'($urandom_range(0, 99)) < free_pct) begin
            free_q.push_back(make_req(free_id));
            free_id++;
        end
        case (af_mode)
            AF_RANDOM: begin
                if ($urandom_range(0, 15) == 0) alloc_rsp_almost_full = !alloc_rsp_almost_full;
                if ($urandom_range(0, 15) == 0) free_rsp_almost_full = !free_rsp_almost_full;
            end
            AF_FREE_FULL: begin
                alloc_rsp_almost_full = 1'b0;
                free_rsp_almost_full  = 1'b1;    // lets the free backlog build up
            end
            default: begin
                alloc_rsp_almost_full = 1'b0;
                free_rsp_almost_full  = 1'b0;
            end
        endcase
        alloc_empty = (alloc_q.size() == 0);
        free_empty  = (free_q.size() == 0);
        free_count  = (free_q.size() > 127) ? 7'd127 : 7'(free_q.size());
    endtask

    initial begin
        void'($urandom(32'hda51_e608));
        clk = 1'b0;
        rst_n = 1'b0;
        alloc_req = '0;
        free_req = '0;
        alloc_out = '0;
        free_out = '0;
        alloc_empty = 1'b1;
        free_empty = 1'b1;
        free_count = '0;
        alloc_rsp_almost_full = 1'b0;
        free_rsp_almost_full = 1'b0;
        alloc_id = '0;
        free_id = '0;
        cycle = 0;
        value_errors = 0;
        other_errors = 0;
        quiet = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (8) drive_cycle(0, 0, AF_CLEAR);
        quiet = 1'b0;
        repeat (1500) drive_cycle(10, 10, AF_RANDOM);
        repeat (80) drive_cycle(25, 100, AF_FREE_FULL);   // push free past the threshold
        repeat (400) drive_cycle(15, 10, AF_CLEAR);

        wait_cycles = 0;
        while (!all_done() && wait_cycles < DRAIN_TIMEOUT) begin
            drive_cycle(0, 0, AF_CLEAR);
            wait_cycles++;
        end
        if (!all_done()) begin
            other_errors++;
            $display("timeout: requests still outstanding after %0d drain cycles",
                     DRAIN_TIMEOUT);
        end
        repeat (20) drive_cycle(0, 0, AF_CLEAR);  // catch stray results

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
verilog/mmu_types_pkg.sv
verilog/dispatch_ctrl_pkg.sv
verilog/dispatch_fsm.sv
verilog/switch_timer.sv
verilog/req_screen.sv
verilog/mmu_dispatcher.sv
verif/tb_mmu_dispatcher.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run the dispatcher testbench
# build output goes to build.log, simulation output to sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f sim.f --top-module tb_mmu_dispatcher \
    -o tb_mmu_dispatcher > build.log 2>&1 \
    && ./obj_dir/tb_mmu_dispatcher > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -qx "TEST PASS" sim.log \
    && echo "simulation result: passed" \
    || { echo "simulation result: failed"; exit 1; }
